/* hdl/cachePkg.sv */
// Shared sizes, address split helpers and payload types for the 2-way data cache; use by scoped names
package cachePkg;

    // Core bus widths
    localparam int addrWidth = 32;
    localparam int wordWidth = 64;

    // Line geometry, 8 words of 8 bytes
    localparam int wordsPerLine = 8;
    localparam int offsetBits = 6;
    localparam int wordByteBits = $clog2(wordWidth / 8);
    localparam int wordSelBits = $clog2(wordsPerLine);

    // 16 sets per way
    localparam int indexBits = 4;
    localparam int numSets = 1 << indexBits;

    // Whatever is left above index and offset
    localparam int tagBits = addrWidth - indexBits - offsetBits;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [wordWidth-1:0] wordT;
    // Word 0 sits in the low bits
    typedef logic [wordsPerLine*wordWidth-1:0] lineT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [indexBits-1:0] indexT;
    typedef logic [wordSelBits-1:0] wordSelT;

    // Upper address bits kept in the tag arrays
    function automatic tagT addrTag(addrT addr);
        return addr[addrWidth-1 -: tagBits];
    endfunction

    // Set selected by an address
    function automatic indexT addrIndex(addrT addr);
        return addr[offsetBits +: indexBits];
    endfunction

    // Word position inside the line, byte bits dropped
    function automatic wordSelT addrWordSel(addrT addr);
        return addr[wordByteBits +: wordSelBits];
    endfunction

    // Start of the line, used for fill requests
    function automatic addrT lineAddr(addrT addr);
        return {addr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
    endfunction

endpackage

/* hdl/syncRam.sv */
// Single read, single write synchronous array of one entry per set; holds tags or lines by type
`timescale 1ns/10ps

module syncRam #(
    // Payload stored per set
    parameter type payloadT = cachePkg::wordT
) (
    input  logic            rwArbiterCacheBus,
    input  cachePkg::indexT readIndex,
    output payloadT         readData,
    input  cachePkg::indexT writeIndex,
    input  payloadT         writeData,
    input  logic            writeEn
);

    // One entry per set
    payloadT mem [cachePkg::numSets];

    // Write port
    always_ff @(posedge rwArbiterCacheBus) begin
        if (writeEn) begin
            mem[writeIndex] <= writeData;
        end
    end

    // Registered read, data one cycle after the index
    // Same-index write in the same cycle returns the old entry
    always_ff @(posedge rwArbiterCacheBus) begin
        readData <= mem[readIndex];
    end

endmodule

/* hdl/setStateTable.sv */
// Per-set valid bits and most-recently-used way; picks the victim for a fill, cleared by reset
`timescale 1ns/10ps

module setStateTable (
    input  logic            rwArbiterCacheBus,
    input  logic            rstN,
    input  cachePkg::indexT lookupIndex,
    output logic [1:0]      validWays,
    output logic            victimWay,
    input  logic            fillDone,
    input  logic            fillWay,
    input  logic            touch,
    input  logic            touchWay
);

    // Valid bit of each way, one bit per set
    logic [cachePkg::numSets-1:0] validWay0;
    logic [cachePkg::numSets-1:0] validWay1;

    // Way used last in each set, 1 means way 1
    logic [cachePkg::numSets-1:0] mruWay;

    // Updates always apply to the set being looked up
    always_ff @(posedge rwArbiterCacheBus or negedge rstN) begin
        if (!rstN) begin
            validWay0 <= '0;
            validWay1 <= '0;
            mruWay <= '0;
        end else begin
            // Line and tag are in place, way becomes valid
            if (fillDone) begin
                if (fillWay) begin
                    validWay1[lookupIndex] <= 1'b1;
                end else begin
                    validWay0[lookupIndex] <= 1'b1;
                end
            end
            // End of a request
            if (touch) begin
                mruWay[lookupIndex] <= touchWay;
            end
        end
    end

    // Combinational read of the current set
    assign validWays = {validWay1[lookupIndex], validWay0[lookupIndex]};

    // Free way first, way 0 before way 1
    // With both valid, evict the one not used last
    always_comb begin
        if (!validWay0[lookupIndex]) begin
            victimWay = 1'b0;
        end else if (!validWay1[lookupIndex]) begin
            victimWay = 1'b1;
        end else begin
            victimWay = ~mruWay[lookupIndex];
        end
    end

endmodule

/* hdl/lineFillBuffer.sv */
// Assembles the eight memory beats of a line fill and merges a store word into a line
`timescale 1ns/10ps

module lineFillBuffer (
    input  logic              rwArbiterCacheBus,
    input  logic              rstN,
    input  logic              beatValid,
    input  cachePkg::wordT    beatData,
    input  logic              fillStart,
    output cachePkg::lineT    lineOut,
    input  cachePkg::lineT    baseLine,
    input  cachePkg::wordSelT mergeSel,
    input  cachePkg::wordT    mergeWord,
    output cachePkg::lineT    mergedLine
);

    // Next word slot to fill
    cachePkg::wordSelT beatCount;

    // Line under construction
    cachePkg::lineT lineReg;

    // Beat position, back to word 0 for each new fill
    always_ff @(posedge rwArbiterCacheBus or negedge rstN) begin
        if (!rstN) begin
            beatCount <= '0;
        end else if (fillStart) begin
            beatCount <= '0;
        end else if (beatValid) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    // Beats arrive in word order
    always_ff @(posedge rwArbiterCacheBus) begin
        if (beatValid) begin
            lineReg[beatCount*cachePkg::wordWidth +: cachePkg::wordWidth] <= beatData;
        end
    end

    assign lineOut = lineReg;

    // Store merge, all other words pass unchanged
    always_comb begin
        mergedLine = baseLine;
        mergedLine[mergeSel*cachePkg::wordWidth +: cachePkg::wordWidth] = mergeWord;
    end

endmodule

/* hdl/cacheController.sv */
// FSM of the cache: lookup, line fill, write-through and both request/response handshakes
`timescale 1ns/10ps

module cacheController (
    input  logic              rwArbiterCacheBus,
    input  logic              rstN,
    // Core side
    input  logic              reqCyc,
    input  cachePkg::addrT    reqAddr,
    input  logic              reqWe,
    input  cachePkg::wordT    reqData,
    output logic              reqAck,
    output logic              respCyc,
    input  logic              respAck,
    output cachePkg::wordT    respData,
    // Memory side
    output logic              memReqCyc,
    input  logic              memReqAck,
    output cachePkg::addrT    memAddr,
    output logic              memWe,
    output cachePkg::wordT    memData,
    input  logic              memRespCyc,
    output logic              memRespAck,
    // Tag and line arrays
    output cachePkg::indexT   ramIndex,
    input  cachePkg::tagT     tagWay0,
    input  cachePkg::tagT     tagWay1,
    input  cachePkg::lineT    lineWay0,
    input  cachePkg::lineT    lineWay1,
    output cachePkg::tagT     tagWrite,
    output cachePkg::lineT    lineWrite,
    output logic [1:0]        wayWriteEn,
    // State table
    input  logic [1:0]        validWays,
    input  logic              victimWay,
    output logic              fillDone,
    output logic              fillWay,
    output logic              touch,
    output logic              touchWay,
    // Fill buffer
    output logic              beatValid,
    output logic              fillStart,
    input  cachePkg::lineT    filledLine,
    output cachePkg::lineT    baseLine,
    output cachePkg::wordSelT mergeSel,
    output cachePkg::wordT    mergeWord,
    input  cachePkg::lineT    mergedLine
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        fill,
        fillWrite,
        memWrite,
        respond
    } stateT;

    localparam cachePkg::wordSelT lastBeat = cachePkg::wordSelT'(cachePkg::wordsPerLine - 1);

    stateT state;

    // Request held for the whole transaction
    cachePkg::addrT reqAddrReg;
    cachePkg::wordT reqDataReg;
    logic reqWeReg;

    // Way being served, hit way or victim
    logic useWay;
    cachePkg::wordSelT beatCount;

    // Tag compare
    logic hitWay0;
    logic hitWay1;
    logic hit;
    logic hitWay;
    cachePkg::lineT hitLine;

    // Transaction steps
    logic acceptReq;
    logic missStart;
    logic writeStart;
    logic readDone;

    // Tags compared only where the way holds a line
    assign hitWay0 = validWays[0] && (tagWay0 == cachePkg::addrTag(reqAddrReg));
    assign hitWay1 = validWays[1] && (tagWay1 == cachePkg::addrTag(reqAddrReg));
    assign hit = hitWay0 || hitWay1;
    assign hitWay = !hitWay0;
    assign hitLine = hitWay ? lineWay1 : lineWay0;

    assign acceptReq = (state == idle) && reqCyc;
    assign missStart = (state == lookup) && !hit;
    // Store leaves through memory after a hit or after its fill
    assign writeStart = reqWeReg && (((state == lookup) && hit) || (state == fillWrite));
    assign readDone = !reqWeReg && (((state == lookup) && hit) || (state == fillWrite));

    // Arrays read the incoming index in idle so tags are ready in lookup
    assign ramIndex = (state == idle) ? cachePkg::addrIndex(reqAddr)
                                      : cachePkg::addrIndex(reqAddrReg);

    // Hit line in lookup, freshly filled line afterwards
    assign baseLine = (state == lookup) ? hitLine : filledLine;
    assign mergeSel = cachePkg::addrWordSel(reqAddrReg);
    assign mergeWord = reqDataReg;

    // Array writes: merged store on a write hit, whole line after a fill
    always_comb begin
        wayWriteEn = 2'b00;
        if ((state == lookup) && hit && reqWeReg) begin
            wayWriteEn = hitWay ? 2'b10 : 2'b01;
        end else if (state == fillWrite) begin
            wayWriteEn = useWay ? 2'b10 : 2'b01;
        end
    end
    assign tagWrite = cachePkg::addrTag(reqAddrReg);
    assign lineWrite = ((state == fillWrite) && !reqWeReg) ? filledLine : mergedLine;

    // State table
    assign fillDone = (state == fillWrite);
    assign fillWay = useWay;
    // Once per request, as the core takes the response
    assign touch = (state == respond) && respAck;
    assign touchWay = useWay;

    // Beats accepted only during a fill
    assign beatValid = (state == fill) && memRespCyc;
    assign memRespAck = beatValid;
    assign fillStart = missStart;

    always_ff @(posedge rwArbiterCacheBus or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            reqAck <= 1'b0;
            respCyc <= 1'b0;
            memReqCyc <= 1'b0;
            memWe <= 1'b0;
            useWay <= 1'b0;
            beatCount <= '0;
        end else begin
            // One-cycle pulse
            reqAck <= acceptReq;
            if (acceptReq) begin
                state <= lookup;
            end
            if (state == lookup) begin
                useWay <= hit ? hitWay : victimWay;
            end
            if (missStart) begin
                memReqCyc <= 1'b1;
                memWe <= 1'b0;
                beatCount <= '0;
                state <= fill;
            end
            // Request may be acknowledged late, beats are counted regardless
            if ((state == fill) && memReqAck) begin
                memReqCyc <= 1'b0;
            end
            if (beatValid) begin
                beatCount <= beatCount + 1'b1;
                if (beatCount == lastBeat) begin
                    state <= fillWrite;
                end
            end
            if (writeStart) begin
                memReqCyc <= 1'b1;
                memWe <= 1'b1;
                state <= memWrite;
            end
            if (readDone) begin
                respCyc <= 1'b1;
                state <= respond;
            end
            // Store is answered once memory has taken the word
            if ((state == memWrite) && memReqAck) begin
                memReqCyc <= 1'b0;
                respCyc <= 1'b1;
                state <= respond;
            end
            if ((state == respond) && respAck) begin
                respCyc <= 1'b0;
                state <= idle;
            end
        end
    end

    // Request and bus payload
    always_ff @(posedge rwArbiterCacheBus) begin
        if (acceptReq) begin
            reqAddrReg <= reqAddr;
            reqDataReg <= reqData;
            reqWeReg <= reqWe;
        end
        if (missStart) begin
            memAddr <= cachePkg::lineAddr(reqAddrReg);
        end
        // Write-through of the single stored word
        if (writeStart) begin
            memAddr <= reqAddrReg;
            memData <= reqDataReg;
        end
        if (readDone) begin
            respData <= baseLine[mergeSel*cachePkg::wordWidth +: cachePkg::wordWidth];
        end
    end

endmodule

/* hdl/setAssocCache.sv */
// Top of the 2-way set-associative data cache, with one core port and one memory port
`timescale 1ns/10ps

module setAssocCache (
    input  logic           rwArbiterCacheBus,
    input  logic           rstN,
    // Core side
    input  logic           reqCyc,
    input  cachePkg::addrT reqAddr,
    input  logic           reqWe,
    input  cachePkg::wordT reqData,
    output logic           reqAck,
    output logic           respCyc,
    input  logic           respAck,
    output cachePkg::wordT respData,
    // Memory side
    output logic           memReqCyc,
    input  logic           memReqAck,
    output cachePkg::addrT memAddr,
    output logic           memWe,
    output cachePkg::wordT memData,
    input  logic           memRespCyc,
    input  cachePkg::wordT memRespData,
    output logic           memRespAck
);

    // Arrays
    cachePkg::indexT ramIndex;
    cachePkg::tagT tagWay0;
    cachePkg::tagT tagWay1;
    cachePkg::lineT lineWay0;
    cachePkg::lineT lineWay1;
    cachePkg::tagT tagWrite;
    cachePkg::lineT lineWrite;
    logic [1:0] wayWriteEn;

    // State table
    logic [1:0] validWays;
    logic victimWay;
    logic fillDone;
    logic fillWay;
    logic touch;
    logic touchWay;

    // Fill buffer
    logic beatValid;
    logic fillStart;
    cachePkg::lineT filledLine;
    cachePkg::lineT baseLine;
    cachePkg::wordSelT mergeSel;
    cachePkg::wordT mergeWord;
    cachePkg::lineT mergedLine;

    cacheController u_ctrl (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN),
        .reqCyc(reqCyc), .reqAddr(reqAddr), .reqWe(reqWe), .reqData(reqData),
        .reqAck(reqAck), .respCyc(respCyc), .respAck(respAck), .respData(respData),
        .memReqCyc(memReqCyc), .memReqAck(memReqAck), .memAddr(memAddr), .memWe(memWe),
        .memData(memData), .memRespCyc(memRespCyc), .memRespAck(memRespAck),
        .ramIndex(ramIndex), .tagWay0(tagWay0), .tagWay1(tagWay1),
        .lineWay0(lineWay0), .lineWay1(lineWay1), .tagWrite(tagWrite),
        .lineWrite(lineWrite), .wayWriteEn(wayWriteEn),
        .validWays(validWays), .victimWay(victimWay), .fillDone(fillDone),
        .fillWay(fillWay), .touch(touch), .touchWay(touchWay),
        .beatValid(beatValid), .fillStart(fillStart), .filledLine(filledLine),
        .baseLine(baseLine), .mergeSel(mergeSel), .mergeWord(mergeWord),
        .mergedLine(mergedLine)
    );

    setStateTable u_state (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN), .lookupIndex(ramIndex),
        .validWays(validWays), .victimWay(victimWay), .fillDone(fillDone),
        .fillWay(fillWay), .touch(touch), .touchWay(touchWay)
    );

    lineFillBuffer u_fill (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN), .beatValid(beatValid),
        .beatData(memRespData), .fillStart(fillStart), .lineOut(filledLine),
        .baseLine(baseLine), .mergeSel(mergeSel), .mergeWord(mergeWord),
        .mergedLine(mergedLine)
    );

    // Way 0 tag and data
    syncRam #(.payloadT(cachePkg::tagT)) u_tagWay0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .readIndex(ramIndex), .readData(tagWay0),
        .writeIndex(ramIndex), .writeData(tagWrite), .writeEn(wayWriteEn[0])
    );

    syncRam #(.payloadT(cachePkg::lineT)) u_lineWay0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .readIndex(ramIndex), .readData(lineWay0),
        .writeIndex(ramIndex), .writeData(lineWrite), .writeEn(wayWriteEn[0])
    );

    // Way 1 tag and data
    syncRam #(.payloadT(cachePkg::tagT)) u_tagWay1 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .readIndex(ramIndex), .readData(tagWay1),
        .writeIndex(ramIndex), .writeData(tagWrite), .writeEn(wayWriteEn[1])
    );

    syncRam #(.payloadT(cachePkg::lineT)) u_lineWay1 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .readIndex(ramIndex), .readData(lineWay1),
        .writeIndex(ramIndex), .writeData(lineWrite), .writeEn(wayWriteEn[1])
    );

endmodule

/* tb/tbClockGen.sv */
// Testbench clock and reset source for the cache testbench; instantiate once in the testbench top
`timescale 1ns/10ps

module tbClockGen #(
    parameter int periodNs = 40,
    parameter int resetCycles = 5
) (
    output logic rwArbiterCacheBus,
    output logic rstN
);

    // Free-running clock, starts low
    initial begin
        rwArbiterCacheBus = 1'b0;
        forever begin
            #(periodNs / 2) rwArbiterCacheBus = ~rwArbiterCacheBus;
        end
    end

    // Reset held for a fixed number of cycles, released away from the rising edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge rwArbiterCacheBus);
        @(negedge rwArbiterCacheBus);
        rstN = 1'b1;
    end

endmodule

/* tb/setAssocCache_assertions.sv */
// Concurrent handshake checks on the cache top, attached to setAssocCache by bind below
`timescale 1ns/10ps

module setAssocCacheAssertions (
    input logic           rwArbiterCacheBus,
    input logic           rstN,
    input logic           reqAck,
    input logic           respCyc,
    input logic           respAck,
    input cachePkg::wordT respData,
    input logic           memReqCyc,
    input logic           memReqAck,
    input cachePkg::addrT memAddr
);

    // Read by the testbench top at the end of the run
    int violationCount = 0;

    // Accept pulse lasts a single cycle
    assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
        reqAck |=> !reqAck)
    else begin
        violationCount++;
        $error("reqAck high for more than one cycle");
    end

    // Response held with its data until the core takes it
    assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
        respCyc && !respAck |=> respCyc && $stable(respData))
    else begin
        violationCount++;
        $error("respCyc or respData changed before respAck");
    end

    // Memory request and address held until memory acknowledges
    assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
        memReqCyc && !memReqAck |=> memReqCyc && $stable(memAddr))
    else begin
        violationCount++;
        $error("memReqCyc or memAddr changed before memReqAck");
    end

    // Core-side outputs quiet while reset is asserted
    assert property (@(posedge rwArbiterCacheBus) !rstN |-> !reqAck && !respCyc)
    else begin
        violationCount++;
        $error("core-side output high during reset");
    end

endmodule

bind setAssocCache setAssocCacheAssertions u_assert (
    .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN), .reqAck(reqAck),
    .respCyc(respCyc), .respAck(respAck), .respData(respData),
    .memReqCyc(memReqCyc), .memReqAck(memReqAck), .memAddr(memAddr)
);

/* tb/setAssocCacheTb.sv */
// Table-driven testbench of the cache with a randomized memory model and a watchdog; top module
`timescale 1ns/10ps

module setAssocCacheTb;

    localparam int periodNs = 40;
    localparam int resetCycles = 5;
    // Twice the worst fill plus write plus response hold
    localparam int cyclesPerRow = 120;
    localparam int bytesPerWord = cachePkg::wordWidth / 8;
    localparam cachePkg::wordT patternKey = 64'h3C96_A5F0_0F5A_69C3;

    logic rwArbiterCacheBus;
    logic rstN;
    logic reqCyc;
    cachePkg::addrT reqAddr;
    logic reqWe;
    cachePkg::wordT reqData;
    logic reqAck;
    logic respCyc;
    logic respAck;
    cachePkg::wordT respData;
    logic memReqCyc;
    logic memReqAck;
    cachePkg::addrT memAddr;
    logic memWe;
    cachePkg::wordT memData;
    logic memRespCyc;
    cachePkg::wordT memRespData;
    logic memRespAck;

    integer seed = 32'ha870_02c3;

    // Memory contents by word address
    // Unwritten words follow the address pattern
    cachePkg::wordT memory [cachePkg::addrT];
    int fillCount = 0;
    int writeCount = 0;
    cachePkg::addrT lastFillAddr;
    cachePkg::addrT lastWriteAddr;
    cachePkg::wordT lastWriteData;

    // Operation table with one entry per row in each queue
    logic rowWrite [$];
    cachePkg::addrT rowAddr [$];
    cachePkg::wordT rowData [$];
    cachePkg::wordT rowExpData [$];
    int rowFills [$];
    int rowWrites [$];
    int rowHold [$];
    logic tableReady = 1'b0;

    tbClockGen #(.periodNs(periodNs), .resetCycles(resetCycles)) u_clk (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN)
    );

    setAssocCache u_dut (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rstN(rstN),
        .reqCyc(reqCyc), .reqAddr(reqAddr), .reqWe(reqWe), .reqData(reqData),
        .reqAck(reqAck), .respCyc(respCyc), .respAck(respAck), .respData(respData),
        .memReqCyc(memReqCyc), .memReqAck(memReqAck), .memAddr(memAddr), .memWe(memWe),
        .memData(memData), .memRespCyc(memRespCyc), .memRespData(memRespData),
        .memRespAck(memRespAck)
    );

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input cachePkg::wordT got,
                             input cachePkg::wordT exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkAddr(input string name, input cachePkg::addrT got,
                             input cachePkg::addrT exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    // Word address XOR a fixed key
    function automatic cachePkg::wordT patternWord(input cachePkg::addrT addr);
        return cachePkg::wordT'(addr / bytesPerWord) ^ patternKey;
    endfunction

    function automatic cachePkg::wordT modelRead(input cachePkg::addrT addr);
        cachePkg::addrT wordAddr;
        wordAddr = addr / bytesPerWord;
        if (memory.exists(wordAddr)) begin
            return memory[wordAddr];
        end
        return patternWord(addr);
    endfunction

    task automatic addRow(input logic we, input cachePkg::addrT addr, input cachePkg::wordT data,
                          input cachePkg::wordT expData, input int fills, input int writes);
        rowWrite.push_back(we);
        rowAddr.push_back(addr);
        rowData.push_back(data);
        rowExpData.push_back(expData);
        rowFills.push_back(fills);
        rowWrites.push_back(writes);
        // Response back-pressure of zero to three cycles
        rowHold.push_back($unsigned($random(seed)) % 4);
    endtask

    // Eight beats in word order
    // Each beat held until the cache takes it
    task automatic sendLine(input cachePkg::addrT base);
        int gap;
        int b;
        for (b = 0; b < cachePkg::wordsPerLine; b++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge rwArbiterCacheBus);
            memRespCyc = 1'b1;
            memRespData = modelRead(cachePkg::addrT'(base + b * bytesPerWord));
            #1;
            while (memRespAck !== 1'b1) begin
                @(negedge rwArbiterCacheBus);
                #1;
            end
            @(negedge rwArbiterCacheBus);
            memRespCyc = 1'b0;
        end
    endtask

    // Memory model with random acknowledge delay
    initial begin : memoryModel
        cachePkg::addrT addr;
        logic isWrite;
        memReqAck = 1'b0;
        memRespCyc = 1'b0;
        memRespData = '0;
        forever begin
            @(negedge rwArbiterCacheBus);
            if (memReqCyc === 1'b1) begin
                repeat ($unsigned($random(seed)) % 4) @(negedge rwArbiterCacheBus);
                addr = memAddr;
                isWrite = memWe;
                memReqAck = 1'b1;
                if (isWrite) begin
                    memory[addr / bytesPerWord] = memData;
                    writeCount++;
                    lastWriteAddr = addr;
                    lastWriteData = memData;
                end else begin
                    fillCount++;
                    lastFillAddr = addr;
                end
                @(negedge rwArbiterCacheBus);
                memReqAck = 1'b0;
                if (!isWrite) begin
                    sendLine(addr);
                end
            end
        end
    end

    // One complete request checked against row r
    task automatic runRow(input int r);
        int fillsBefore;
        int writesBefore;
        int ackWait;
        cachePkg::wordT heldData;
        fillsBefore = fillCount;
        writesBefore = writeCount;
        reqCyc = 1'b1;
        reqAddr = rowAddr[r];
        reqWe = rowWrite[r];
        reqData = rowData[r];
        ackWait = 0;
        do begin
            @(negedge rwArbiterCacheBus);
            ackWait++;
        end while (reqAck !== 1'b1);
        reqCyc = 1'b0;
        reqWe = 1'b0;
        @(negedge rwArbiterCacheBus);
        // Read hit is accepted at once and answers in the cycle after reqAck
        if (!rowWrite[r] && rowFills[r] == 0) begin
            checkCount("reqAck cycles after reqCyc", ackWait, 1);
            checkCount("respCyc one cycle after reqAck", int'(respCyc), 1);
        end
        while (respCyc !== 1'b1) @(negedge rwArbiterCacheBus);
        heldData = respData;
        repeat (rowHold[r]) begin
            @(negedge rwArbiterCacheBus);
            checkCount("respCyc while respAck low", int'(respCyc), 1);
            checkWord("respData while respAck low", respData, heldData);
        end
        respAck = 1'b1;
        @(negedge rwArbiterCacheBus);
        respAck = 1'b0;
        checkCount("respCyc after respAck", int'(respCyc), 0);
        if (!rowWrite[r]) begin
            checkWord("respData", heldData, rowExpData[r]);
        end
        checkCount("fill requests", fillCount - fillsBefore, rowFills[r]);
        checkCount("memory writes", writeCount - writesBefore, rowWrites[r]);
        if (rowFills[r] > 0) begin
            checkAddr("fill memAddr", lastFillAddr,
                      (rowAddr[r] >> cachePkg::offsetBits) << cachePkg::offsetBits);
        end
        if (rowWrites[r] > 0) begin
            checkAddr("write memAddr", lastWriteAddr, rowAddr[r]);
            checkWord("write memData", lastWriteData, rowData[r]);
        end
    endtask

    initial begin : watchdog
        longint limitNs;
        wait (tableReady);
        limitNs = longint'(rowAddr.size() * cyclesPerRow + resetCycles + 20) * periodNs;
        #(limitNs);
        $display("Timeout: the cache did not finish all table rows within %0d ns", limitNs);
        abortRun();
    end

    initial begin : stimulus
        int r;
        reqCyc = 1'b0;
        reqAddr = '0;
        reqWe = 1'b0;
        reqData = '0;
        respAck = 1'b0;
        // Lines A, B and C share set 1
        // Line D sits in set 6
        addRow(1'b0, 32'h0000_1048, '0, patternWord(32'h0000_1048), 1, 0);
        addRow(1'b0, 32'h0000_1070, '0, patternWord(32'h0000_1070), 0, 0);
        // Write hit then read back
        addRow(1'b1, 32'h0000_1050, 64'hDEAD_BEEF_0123_4567, '0, 0, 1);
        addRow(1'b0, 32'h0000_1050, '0, 64'hDEAD_BEEF_0123_4567, 0, 0);
        // Write miss with fill then word write
        addRow(1'b1, 32'h0000_5180, 64'h0BAD_F00D_89AB_CDEF, '0, 1, 1);
        addRow(1'b0, 32'h0000_5180, '0, 64'h0BAD_F00D_89AB_CDEF, 0, 0);
        addRow(1'b0, 32'h0000_5188, '0, patternWord(32'h0000_5188), 0, 0);
        // Replacement with B filled into way 1
        // A touched before C evicts B
        addRow(1'b0, 32'h0000_2040, '0, patternWord(32'h0000_2040), 1, 0);
        addRow(1'b0, 32'h0000_1040, '0, patternWord(32'h0000_1040), 0, 0);
        addRow(1'b0, 32'h0000_3078, '0, patternWord(32'h0000_3078), 1, 0);
        addRow(1'b0, 32'h0000_1050, '0, 64'hDEAD_BEEF_0123_4567, 0, 0);
        addRow(1'b0, 32'h0000_2040, '0, patternWord(32'h0000_2040), 1, 0);
        // C then A refetched
        // A comes back from written-through memory
        addRow(1'b0, 32'h0000_3078, '0, patternWord(32'h0000_3078), 1, 0);
        addRow(1'b0, 32'h0000_1050, '0, 64'hDEAD_BEEF_0123_4567, 1, 0);
        tableReady = 1'b1;

        wait (rstN === 1'b1);
        @(negedge rwArbiterCacheBus);
        checkCount("reqAck after reset", int'(reqAck), 0);
        checkCount("respCyc after reset", int'(respCyc), 0);
        checkCount("memReqCyc after reset", int'(memReqCyc), 0);
        checkCount("memRespAck after reset", int'(memRespAck), 0);

        for (r = 0; r < rowAddr.size(); r++) begin
            runRow(r);
        end
        repeat (2) @(negedge rwArbiterCacheBus);

        // Handshake assertion count of the bound checker
        if (u_dut.u_assert.violationCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Assertion failures in the handshake checks: %0d",
                     u_dut.u_assert.violationCount);
            abortRun();
        end
    end

endmodule

/* setAssocCache.f */
hdl/cachePkg.sv
hdl/syncRam.sv
hdl/setStateTable.sv
hdl/lineFillBuffer.sv
hdl/cacheController.sv
hdl/setAssocCache.sv
tb/tbClockGen.sv
tb/setAssocCache_assertions.sv
tb/setAssocCacheTb.sv
